// File: run_sim.sh
#!/usr/bin/env bash
# Build the rename stage testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f \
   --top-module rn_tb \
   -Mdir "$BUILD_DIR" \
   -o rn_tb_sim

# Let every assertion failure through so the closing line gets printed
"./$BUILD_DIR/rn_tb_sim" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -qx "Simulation passed" "$LOG_FILE"; then
   exit 0
else
   echo "Run did not pass, see $LOG_FILE"
   exit 1
fi

// File: src/cmt_pkg.sv
`include "rn_params.svh"

package cmt_pkg;

   import rn_pkg::*;

   // Op leaving the core in program order
   typedef struct packed {
      lreg_t lrd;
      preg_t prd;
      preg_t pfree;  // Returned to the free list
      logic  prd_we;
   } cmt_t;

   // Result written to the physical register file
   typedef struct packed {
      preg_t prd;
   } wb_t;

endpackage

// File: src/rn.sv
`timescale 1ns/1ps
`include "rn_params.svh"

module rn
   import rn_pkg::*;
   import cmt_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  rn_op_t                 in_op,
   output logic                   in_ready,
   output logic                   out_valid,
   output issue_op_t              out_op,
   input  logic                   out_ready,
   input  logic                   commit_valid,
   input  cmt_t                   commit,
   input  logic                   wb_valid,
   input  wb_t                    wb,
   input  logic                   flush,
   output logic [`NCPU_PRF_N-1:0] busytable
);

   preg_t     fl_prd;
   logic      fl_empty;
   preg_t     rat_prs1;
   preg_t     rat_prs2;
   preg_t     rat_pfree;
   logic      p_ce;      // Issue register can take a new op
   logic      accept;
   logic      alloc;     // Accepted op that writes a register
   issue_op_t issue_nxt;

   assign p_ce     = ~out_valid | out_ready;
   assign in_ready = ~fl_empty & p_ce;
   assign accept   = in_valid & in_ready & ~flush;
   assign alloc    = accept & in_op.lrd_we;

   rn_fl U_RN_FL (
      .clk          (clk),
      .rst_n        (rst_n),
      .pop          (alloc),
      .rollback     (flush),
      .commit_valid (commit_valid),
      .commit       (commit),
      .fl_prd       (fl_prd),
      .fl_empty     (fl_empty)
   );

   rn_rat U_RN_RAT (
      .clk          (clk),
      .rst_n        (rst_n),
      .we           (alloc),
      .rollback     (flush),
      .lrs1         (in_op.lrs1),
      .lrs2         (in_op.lrs2),
      .lrd          (in_op.lrd),
      .fl_prd       (fl_prd),
      .commit_valid (commit_valid),
      .commit       (commit),
      .rat_prs1     (rat_prs1),
      .rat_prs2     (rat_prs2),
      .rat_pfree    (rat_pfree)
   );

   rn_busytable U_BUSYTABLE (
      .clk       (clk),
      .rst_n     (rst_n),
      .set_valid (alloc),
      .set_prd   (fl_prd),
      .wb_valid  (wb_valid),
      .wb        (wb),
      .rollback  (flush),
      .busytable (busytable)
   );

   // Renamed op
   always_comb begin
      issue_nxt.opc     = in_op.opc;
      issue_nxt.pc      = in_op.pc;
      issue_nxt.imm     = in_op.imm;
      issue_nxt.prs1    = rat_prs1;
      issue_nxt.prs1_re = in_op.lrs1_re;
      issue_nxt.prs2    = rat_prs2;
      issue_nxt.prs2_re = in_op.lrs2_re;
      issue_nxt.prd     = in_op.lrd_we ? fl_prd : '0;
      issue_nxt.prd_we  = in_op.lrd_we;
      issue_nxt.pfree   = in_op.lrd_we ? rat_pfree : '0; // Nothing to free otherwise
      issue_nxt.lrd     = in_op.lrd;
   end

   // Issue register
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         out_valid <= 1'b0;
      end else if (p_ce) begin
         out_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         out_op <= issue_nxt;
      end
   end

endmodule

// File: src/rn_busytable.sv
`timescale 1ns/1ps
`include "rn_params.svh"

module rn_busytable
   import rn_pkg::*;
   import cmt_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   set_valid,
   input  preg_t                  set_prd,
   input  logic                   wb_valid,
   input  wb_t                    wb,
   input  logic                   rollback,
   output logic [`NCPU_PRF_N-1:0] busytable
);

   always_ff @(posedge clk) begin
      if (!rst_n || rollback) begin
         busytable <= '0;
      end else begin
         // Result ready
         if (wb_valid) begin
            busytable[wb.prd] <= 1'b0;
         end
         // Later assignment wins, so a new rename stays busy
         if (set_valid) begin
            busytable[set_prd] <= 1'b1;
         end
      end
   end

endmodule

// File: src/rn_fl.sv
`timescale 1ns/1ps
`include "rn_params.svh"

module rn_fl
   import rn_pkg::*;
   import cmt_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  pop,
   input  logic  rollback,
   input  logic  commit_valid,
   input  cmt_t  commit,
   output preg_t fl_prd,
   output logic  fl_empty
);

   // Pointer with wrap bit on top
   typedef logic [`NCPU_PRF_AW:0] fl_ptr_t;

   preg_t   fl_mem [`NCPU_PRF_N];
   fl_ptr_t spec_head;
   fl_ptr_t cmt_head;
   fl_ptr_t tail;
   fl_ptr_t cmt_head_nxt;
   logic    push;
   logic    do_pop;

   assign push         = commit_valid & commit.prd_we;
   assign do_pop       = pop & ~fl_empty;
   assign cmt_head_nxt = cmt_head + fl_ptr_t'(push); // Includes this cycle's commit

   // Allocation is combinational from the speculative head
   assign fl_prd   = fl_mem[spec_head[`NCPU_PRF_AW-1:0]];
   assign fl_empty = (spec_head == tail);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         spec_head <= '0;
         cmt_head  <= '0;
         tail      <= fl_ptr_t'(`NCPU_PRF_N - `NCPU_LRF_N);
      end else begin
         cmt_head <= cmt_head_nxt;
         if (push) begin
            tail <= tail + 1'b1;
         end
         // Rollback beats allocation
         if (rollback) begin
            spec_head <= cmt_head_nxt;
         end else if (do_pop) begin
            spec_head <= spec_head + 1'b1;
         end
      end
   end

   // Registers not claimed by the initial mapping start out free
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NCPU_PRF_N - `NCPU_LRF_N; i++) begin
            fl_mem[i] <= preg_t'(`NCPU_LRF_N + i);
         end
      end else if (push) begin
         fl_mem[tail[`NCPU_PRF_AW-1:0]] <= commit.pfree; // Old mapping freed
      end
   end

endmodule

// File: src/rn_params.svh
`ifndef RN_PARAMS_SVH
`define RN_PARAMS_SVH

// Logical register file
`define NCPU_LRF_AW 5
`define NCPU_LRF_N  (1 << `NCPU_LRF_AW)

// Physical register file
`define NCPU_PRF_AW 6
`define NCPU_PRF_N  (1 << `NCPU_PRF_AW)

// Op payload widths
`define PC_W        32
`define CONFIG_DW   32
`define NCPU_OPC_W  8

`endif

// File: src/rn_pkg.sv
`include "rn_params.svh"

package rn_pkg;

   typedef logic [`NCPU_LRF_AW-1:0] lreg_t;
   typedef logic [`NCPU_PRF_AW-1:0] preg_t;
   typedef logic [`PC_W-1:0]        pc_t;
   typedef logic [`CONFIG_DW-1:0]   data_t;
   typedef logic [`NCPU_OPC_W-1:0]  opc_t;

   // Op as it leaves decode
   typedef struct packed {
      opc_t  opc;
      pc_t   pc;
      data_t imm;
      lreg_t lrs1;
      logic  lrs1_re;
      lreg_t lrs2;
      logic  lrs2_re;
      lreg_t lrd;
      logic  lrd_we;
   } rn_op_t;

   // Op handed to issue
   typedef struct packed {
      opc_t  opc;
      pc_t   pc;
      data_t imm;
      preg_t prs1;
      logic  prs1_re;
      preg_t prs2;
      logic  prs2_re;
      preg_t prd;
      logic  prd_we;
      preg_t pfree;  // Old mapping of lrd
      lreg_t lrd;
   } issue_op_t;

endpackage

// File: src/rn_rat.sv
`timescale 1ns/1ps
`include "rn_params.svh"

module rn_rat
   import rn_pkg::*;
   import cmt_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  we,
   input  logic  rollback,
   input  lreg_t lrs1,
   input  lreg_t lrs2,
   input  lreg_t lrd,
   input  preg_t fl_prd,
   input  logic  commit_valid,
   input  cmt_t  commit,
   output preg_t rat_prs1,
   output preg_t rat_prs2,
   output preg_t rat_pfree
);

   preg_t sp_rat   [`NCPU_LRF_N];  // Speculative mapping
   preg_t arch_rat [`NCPU_LRF_N];  // Committed mapping
   preg_t arch_nxt [`NCPU_LRF_N];

   // Lookups see the table before this edge
   assign rat_prs1  = sp_rat[lrs1];
   assign rat_prs2  = sp_rat[lrs2];
   assign rat_pfree = sp_rat[lrd];

   // Committed table with this cycle's commit merged in
   always_comb begin
      arch_nxt = arch_rat;
      if (commit_valid && commit.prd_we) begin
         arch_nxt[commit.lrd] = commit.prd;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Identity mapping out of reset
         for (int i = 0; i < `NCPU_LRF_N; i++) begin
            sp_rat[i]   <= preg_t'(i);
            arch_rat[i] <= preg_t'(i);
         end
      end else begin
         arch_rat <= arch_nxt;
         if (rollback) begin
            sp_rat <= arch_nxt;
         end else if (we) begin
            sp_rat[lrd] <= fl_prd;   // New destination
         end
      end
   end

endmodule

// File: verification/rn_checker.sv
`timescale 1ns/1ps
`include "rn_params.svh"

module rn_checker
   import rn_pkg::*;
   import cmt_pkg::*;
(
   input logic                   clk,
   input logic                   rst_n,
   input logic                   in_valid,
   input rn_op_t                 in_op,
   input logic                   in_ready,
   input logic                   out_valid,
   input issue_op_t              out_op,
   input logic                   out_ready,
   input logic                   commit_valid,
   input cmt_t                   commit,
   input logic                   wb_valid,
   input wb_t                    wb,
   input logic                   flush,
   input logic [`NCPU_PRF_N-1:0] busytable
);

   int                   fail_cnt = 0;
   logic                 acc_q;       // out_op holds a fresh op
   rn_op_t               op_q;        // Op behind out_op
   logic                 prev_vld;
   logic                 prev_we;
   lreg_t                prev_lrd;
   preg_t                prev_prd;
   logic                 post_flush;
   logic [`NCPU_PRF_N-1:0] busy_exp;  // Bits that must be set
   preg_t                arch_sh [`NCPU_LRF_N];
   preg_t                arch_nx [`NCPU_LRF_N];
   preg_t                snap    [`NCPU_LRF_N];  // Mapping right after reset or flush

   always_comb begin
      arch_nx = arch_sh;
      if (commit_valid && commit.prd_we) begin
         arch_nx[commit.lrd] = commit.prd;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_q      <= 1'b0;
         prev_vld   <= 1'b0;
         post_flush <= 1'b1;  // First op sees the identity mapping
         busy_exp   <= '0;
         for (int i = 0; i < `NCPU_LRF_N; i++) begin
            arch_sh[i] <= preg_t'(i);
            snap[i]    <= preg_t'(i);
         end
      end else begin
         acc_q   <= in_valid && in_ready && !flush;
         arch_sh <= arch_nx;
         if (in_valid && in_ready && !flush) begin
            op_q <= in_op;  // Sources are not carried in out_op
         end
         if (flush) begin
            prev_vld   <= 1'b0;
            post_flush <= 1'b1;
            snap       <= arch_nx;
            busy_exp   <= '0;
         end else begin
            if (acc_q) begin
               prev_vld   <= 1'b1;
               prev_we    <= out_op.prd_we;
               prev_lrd   <= out_op.lrd;
               prev_prd   <= out_op.prd;
               post_flush <= 1'b0;
            end
            if (wb_valid) begin
               busy_exp[wb.prd] <= 1'b0;
            end
            if (acc_q && out_op.prd_we) begin
               busy_exp[out_op.prd] <= 1'b1;
            end
         end
      end
   end

   a_reset_quiet: assert property (@(posedge clk)
      !rst_n |=> (!out_valid && busytable == '0))
      else begin
         fail_cnt++;
         $error("Outputs not quiet during or right after reset");
      end

   a_hold_op: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_op)))
      else begin
         fail_cnt++;
         $error("Issue output changed under back-pressure");
      end

   a_stall_in: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |-> !in_ready)
      else begin
         fail_cnt++;
         $error("Input accepted while output stalled");
      end

   // Payload passes through rename untouched
   a_op_payload: assert property (@(posedge clk) disable iff (!rst_n)
      acc_q |-> (out_op.opc == op_q.opc && out_op.pc == op_q.pc && out_op.imm == op_q.imm))
      else begin
         fail_cnt++;
         $error("MISMATCH out_op opc/pc/imm exp %h %h %h got %h %h %h",
            op_q.opc, op_q.pc, op_q.imm, out_op.opc, out_op.pc, out_op.imm);
      end

   a_op_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
      acc_q |-> (out_op.prs1_re == op_q.lrs1_re && out_op.prs2_re == op_q.lrs2_re
         && out_op.prd_we == op_q.lrd_we && out_op.lrd == op_q.lrd
         && (op_q.lrd_we || (out_op.prd == '0 && out_op.pfree == '0))))
      else begin
         fail_cnt++;
         $error("MISMATCH out_op re1/re2/we/lrd exp %h %h %h %h got %h %h %h %h prd %h pfree %h",
            op_q.lrs1_re, op_q.lrs2_re, op_q.lrd_we, op_q.lrd, out_op.prs1_re,
            out_op.prs2_re, out_op.prd_we, out_op.lrd, out_op.prd, out_op.pfree);
      end

   a_busy_new: assert property (@(posedge clk) disable iff (!rst_n)
      (acc_q && out_op.prd_we) |-> busytable[out_op.prd])
      else begin
         fail_cnt++;
         $error("MISMATCH busytable bit %h got 0", out_op.prd);
      end

   a_busy_held: assert property (@(posedge clk) disable iff (!rst_n)
      ((busy_exp & ~busytable) == '0))
      else begin
         fail_cnt++;
         $error("MISMATCH busytable exp_set %h got %h", busy_exp, busytable);
      end

   a_dep_rs1: assert property (@(posedge clk) disable iff (!rst_n)
      (acc_q && prev_vld && prev_we && op_q.lrs1 == prev_lrd) |-> out_op.prs1 == prev_prd)
      else begin
         fail_cnt++;
         $error("MISMATCH prs1 exp %h got %h", prev_prd, out_op.prs1);
      end

   a_dep_rs2: assert property (@(posedge clk) disable iff (!rst_n)
      (acc_q && prev_vld && prev_we && op_q.lrs2 == prev_lrd) |-> out_op.prs2 == prev_prd)
      else begin
         fail_cnt++;
         $error("MISMATCH prs2 exp %h got %h", prev_prd, out_op.prs2);
      end

   a_dep_free: assert property (@(posedge clk) disable iff (!rst_n)
      (acc_q && prev_vld && prev_we && out_op.prd_we && out_op.lrd == prev_lrd)
      |-> out_op.pfree == prev_prd)
      else begin
         fail_cnt++;
         $error("MISMATCH pfree exp %h got %h", prev_prd, out_op.pfree);
      end

   a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
      flush |=> !out_valid)
      else begin
         fail_cnt++;
         $error("Issue register still valid after flush");
      end

   a_flush_map: assert property (@(posedge clk) disable iff (!rst_n)
      (acc_q && post_flush) |-> (out_op.prs1 == snap[op_q.lrs1]
         && out_op.prs2 == snap[op_q.lrs2]
         && (!out_op.prd_we || out_op.pfree == snap[out_op.lrd])))
      else begin
         fail_cnt++;
         $error("MISMATCH prs1/prs2/pfree after flush got %h %h %h",
            out_op.prs1, out_op.prs2, out_op.pfree);
      end

endmodule

bind rn rn_checker U_CHK (.*);

// File: verification/rn_tb.sv
`timescale 1ns/1ps
`include "rn_params.svh"

module rn_tb
   import rn_pkg::*;
   import cmt_pkg::*;
();

   localparam int SEED   = 19;
   localparam int N_EXH  = 40;   // Ops budgeted for draining the free list
   localparam int N_RAND = 300;  // Random stimulus cycles

   logic                   clk;
   logic                   rst_n;
   logic                   in_valid;
   rn_op_t                 in_op;
   logic                   in_ready;
   logic                   out_valid;
   issue_op_t              out_op;
   logic                   out_ready;
   logic                   commit_valid;
   cmt_t                   commit;
   logic                   wb_valid;
   wb_t                    wb;
   logic                   flush;
   logic [`NCPU_PRF_N-1:0] busytable;

   integer    seed;
   issue_op_t issued [$];   // Renamed ops not yet retired
   logic      in_taken;
   logic      retire_en;
   logic      retire_busy;
   int        n_acc;
   int        tb_err;

   tb_clk_gen U_CLK (
      .clk (clk)
   );

   rn UUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_op        (in_op),
      .in_ready     (in_ready),
      .out_valid    (out_valid),
      .out_op       (out_op),
      .out_ready    (out_ready),
      .commit_valid (commit_valid),
      .commit       (commit),
      .wb_valid     (wb_valid),
      .wb           (wb),
      .flush        (flush),
      .busytable    (busytable)
   );

   // Small register range so dependencies show up often
   function automatic rn_op_t rand_op(input logic want_dst);
      rn_op_t op;
      op.opc     = opc_t'($random(seed));
      op.pc      = pc_t'($random(seed));
      op.imm     = data_t'($random(seed));
      op.lrs1    = lreg_t'($random(seed) & 7);
      op.lrs1_re = ($random(seed) & 1) != 0;
      op.lrs2    = lreg_t'($random(seed) & 7);
      op.lrs2_re = ($random(seed) & 1) != 0;
      op.lrd     = lreg_t'($random(seed) & 7);
      op.lrd_we  = want_dst | (($random(seed) & 3) != 0);
      return op;
   endfunction

   task automatic flush_pipeline();
      retire_en = 1'b0;
      @(negedge clk);
      while (retire_busy) @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      issued.delete();  // Uncommitted ops are gone
      retire_en = 1'b1;
   endtask

   // Handshakes seen on the rising edge, before the edge updates anything
   always @(posedge clk) begin
      if (rst_n && !flush) begin
         if (in_valid && in_ready) begin
            in_taken = 1'b1;
            n_acc++;
         end
         if (out_valid && out_ready) begin
            issued.push_back(out_op);
         end
      end
   end

   // In-order writeback then commit
   initial begin : retire_proc
      issue_op_t op;
      int        wait_cyc;
      forever begin
         @(negedge clk);
         if (retire_en && issued.size() > 0) begin
            retire_busy = 1'b1;
            op = issued.pop_front();
            wait_cyc = 1 + ($random(seed) & 3);
            if (op.prd_we) begin
               wb_valid = 1'b1;
               wb.prd   = op.prd;
               @(negedge clk);
               wb_valid = 1'b0;
            end
            repeat (wait_cyc) @(negedge clk);
            commit_valid  = 1'b1;
            commit.lrd    = op.lrd;
            commit.prd    = op.prd;
            commit.pfree  = op.pfree;
            commit.prd_we = op.prd_we;
            @(negedge clk);
            commit_valid = 1'b0;
            retire_busy  = 1'b0;
         end
      end
   end

   initial begin : watchdog
      repeat ((N_EXH + N_RAND) * 20) @(posedge clk);
      $display("Watchdog expired after %0d cycles, run did not finish", (N_EXH + N_RAND) * 20);
      $display("Simulation failed");
      $finish;
   end

   initial begin : stimulus
      int low_cnt;
      int cyc;
      int total;
      seed         = SEED;
      rst_n        = 1'b0;
      in_valid     = 1'b0;
      in_op        = '0;
      out_ready    = 1'b0;
      commit_valid = 1'b0;
      commit       = '0;
      wb_valid     = 1'b0;
      wb           = '0;
      flush        = 1'b0;
      retire_en    = 1'b0;
      retire_busy  = 1'b0;
      in_taken     = 1'b0;
      n_acc        = 0;
      tb_err       = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Commits held off, every op wants a destination
      in_valid  = 1'b1;
      in_op     = rand_op(1'b1);
      out_ready = 1'b1;
      low_cnt   = 0;
      cyc       = 0;
      while (low_cnt < 8 && cyc < N_EXH * 4) begin
         @(negedge clk);
         if (in_taken) begin
            in_taken = 1'b0;
            in_op    = rand_op(1'b1);
            low_cnt  = 0;
         end else begin
            low_cnt++;
         end
         cyc++;
      end
      if (low_cnt < 8) begin
         tb_err++;
         $display("Free list never ran out, rename kept accepting ops");
      end
      assert (n_acc == 32) else begin
         tb_err++;
         $display("MISMATCH rename_count exp %h got %h", 32, n_acc);
      end

      // A commit frees a register and the pending op goes through
      retire_en = 1'b1;
      cyc = 0;
      while (!in_taken && cyc < 50) begin
         @(negedge clk);
         cyc++;
      end
      if (!in_taken) begin
         tb_err++;
         $display("Rename stayed stalled after commits freed registers");
      end

      for (int i = 0; i < N_RAND; i++) begin
         if (i % 100 == 50) begin
            flush_pipeline();
         end
         @(negedge clk);
         if (in_taken || !in_valid) begin
            in_taken = 1'b0;
            in_valid = ($random(seed) & 3) != 0;
            in_op    = rand_op(1'b0);
         end
         out_ready = ($random(seed) & 3) != 0;
      end

      // Drain everything still in flight
      while (in_valid && !in_taken) @(negedge clk);
      in_valid  = 1'b0;
      out_ready = 1'b1;
      while (issued.size() > 0 || retire_busy || out_valid) @(negedge clk);
      repeat (4) @(negedge clk);
      assert (busytable == '0) else begin
         tb_err++;
         $display("MISMATCH busytable exp %h got %h", {`NCPU_PRF_N{1'b0}}, busytable);
      end

      total = tb_err + UUT.U_CHK.fail_cnt;
      $display("Errors: checker %0d, testbench %0d, total %0d",
         UUT.U_CHK.fail_cnt, tb_err, total);
      if (total == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk
);

   localparam int HALF_PERIOD = 5;  // 10 ns period

   initial begin
      clk = 1'b0;
   end

   always #HALF_PERIOD clk = ~clk;

endmodule

// File: verilog.f
+incdir+src
src/rn_pkg.sv
src/cmt_pkg.sv
src/rn_fl.sv
src/rn_rat.sv
src/rn_busytable.sv
src/rn.sv
verification/tb_clk_gen.sv
verification/rn_checker.sv
verification/rn_tb.sv
